// File: build.f
+incdir+sim
hw/alu_pkg.sv
hw/operand_stage.sv
hw/adder_unit.sv
hw/logic_shift_unit.sv
hw/compare_unit.sv
hw/result_stage.sv
hw/int_alu_core.sv
sim/alu_asserts.sv
sim/alu_tb.sv

// File: hw/adder_unit.sv
// Add and subtract unit
module adder_unit (
    input  alu_pkg::alu_req_t  req,
    output alu_pkg::unit_out_t out
);
    import alu_pkg::*;

    localparam data_t SAT_MAX = {1'b0, {(DATA_WIDTH-1){1'b1}}};
    localparam data_t SAT_MIN = {1'b1, {(DATA_WIDTH-1){1'b0}}};

    op_low_t             low;
    logic                hit;
    logic                is_sub;
    logic                sat;
    logic [DATA_WIDTH:0] ext;                                 // Extra bit holds carry or borrow
    logic                sign_a;
    logic                sign_b;
    logic                sign_r;
    logic                ovf;

    assign low = req.opcode[LOW_WIDTH-1:0];

    always_comb begin
        hit    = 1'b0;
        is_sub = 1'b0;
        sat    = 1'b0;
        case (low)
            op_low_t'(OP_ADD):    hit = 1'b1;
            op_low_t'(OP_SUB):    begin hit = 1'b1; is_sub = 1'b1; end
            op_low_t'(OP_ADDSAT): begin hit = 1'b1; sat = 1'b1; end
            op_low_t'(OP_SUBSAT): begin hit = 1'b1; is_sub = 1'b1; sat = 1'b1; end
            default:              hit = 1'b0;
        endcase
    end

    assign ext = is_sub ? {1'b0, req.a} - {1'b0, req.b}
                        : {1'b0, req.a} + {1'b0, req.b};

    assign sign_a = req.a[DATA_WIDTH-1];
    assign sign_b = req.b[DATA_WIDTH-1];
    assign sign_r = ext[DATA_WIDTH-1];

    // Operand signs agree for add, differ for subtract, and the result flips
    assign ovf = ((sign_a ^ sign_b) == is_sub) && (sign_r != sign_a);

    always_comb begin
        out = '0;
        if (hit) begin
            if (sat && ovf) begin
                out.result = sign_a ? SAT_MIN : SAT_MAX;      // Clamp toward the sign of a
            end else begin
                out.result = ext[DATA_WIDTH-1:0];
            end
            out.carry    = ext[DATA_WIDTH] & ~sat;
            out.overflow = ovf;
        end
    end

endmodule

// File: hw/alu_pkg.sv
// Integer ALU shared types
package alu_pkg;

    localparam int DATA_WIDTH   = 32;
    localparam int SHAMT_WIDTH  = 5;                          // log2 of DATA_WIDTH
    localparam int OPCODE_WIDTH = 6;
    localparam int CLASS_WIDTH  = 2;                          // Top opcode bits
    localparam int LOW_WIDTH    = OPCODE_WIDTH - CLASS_WIDTH;

    typedef logic [DATA_WIDTH-1:0]  data_t;
    typedef logic [SHAMT_WIDTH-1:0] shamt_t;
    typedef logic [CLASS_WIDTH-1:0] op_class_t;
    typedef logic [LOW_WIDTH-1:0]   op_low_t;

    // Opcode classes, taken from the top two opcode bits
    localparam op_class_t CLASS_ARITH = 2'b00;
    localparam op_class_t CLASS_LOGIC = 2'b01;
    localparam op_class_t CLASS_CMP   = 2'b10;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_ADD    = 6'b00_0000,
        OP_SUB    = 6'b00_0001,
        OP_ADDSAT = 6'b00_0010,
        OP_SUBSAT = 6'b00_0011,
        OP_AND    = 6'b01_0000,
        OP_OR     = 6'b01_0001,
        OP_XOR    = 6'b01_0010,
        OP_NOT    = 6'b01_0011,
        OP_NOR    = 6'b01_0100,
        OP_SHL    = 6'b01_0101,
        OP_SHR    = 6'b01_0110,
        OP_SAR    = 6'b01_0111,
        OP_ROTL   = 6'b01_1000,
        OP_ROTR   = 6'b01_1001,
        OP_EQ     = 6'b10_0000,
        OP_NE     = 6'b10_0001,
        OP_LTS    = 6'b10_0010,
        OP_LES    = 6'b10_0011,
        OP_GTS    = 6'b10_0100,
        OP_GES    = 6'b10_0101,
        OP_LTU    = 6'b10_0110,
        OP_LEU    = 6'b10_0111,
        OP_GTU    = 6'b10_1000,
        OP_GEU    = 6'b10_1001
    } alu_op_e;

    // Stage-1 request, b already holds the immediate when selected
    typedef struct packed {
        logic    valid;
        alu_op_e opcode;
        data_t   a;
        data_t   b;
    } alu_req_t;

    typedef struct packed {
        data_t result;
        logic  carry;                                         // Carry or borrow
        logic  overflow;                                      // Signed overflow
    } unit_out_t;

    typedef struct packed {
        logic  valid;
        data_t result;
        logic  carry;
        logic  overflow;
        logic  zero;
        logic  negative;
    } alu_resp_t;

endpackage

// File: hw/compare_unit.sv
// Compare unit
module compare_unit (
    input  alu_pkg::alu_req_t  req,
    output alu_pkg::unit_out_t out
);
    import alu_pkg::*;

    op_low_t low;
    logic    lt_s;
    logic    lt_u;
    logic    eq;
    logic    flag;

    assign low  = req.opcode[LOW_WIDTH-1:0];
    assign eq   = (req.a == req.b);
    assign lt_s = ($signed(req.a) < $signed(req.b));
    assign lt_u = (req.a < req.b);

    // Every ordering follows from less-than and equality
    always_comb begin
        case (low)
            op_low_t'(OP_EQ):  flag = eq;
            op_low_t'(OP_NE):  flag = ~eq;
            op_low_t'(OP_LTS): flag = lt_s;
            op_low_t'(OP_LES): flag = lt_s | eq;
            op_low_t'(OP_GTS): flag = ~(lt_s | eq);
            op_low_t'(OP_GES): flag = ~lt_s;
            op_low_t'(OP_LTU): flag = lt_u;
            op_low_t'(OP_LEU): flag = lt_u | eq;
            op_low_t'(OP_GTU): flag = ~(lt_u | eq);
            op_low_t'(OP_GEU): flag = ~lt_u;
            default:           flag = 1'b0;
        endcase
    end

    assign out.result   = {DATA_WIDTH{flag}};                 // All ones when true
    assign out.carry    = 1'b0;
    assign out.overflow = 1'b0;

endmodule

// File: hw/int_alu_core.sv
// Two-stage integer ALU core
module int_alu_core (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid_instruction,
    input  alu_pkg::alu_op_e   opcode,
    input  alu_pkg::data_t     operand_a,
    input  alu_pkg::data_t     operand_b,
    input  logic               use_immediate,
    input  alu_pkg::data_t     immediate_value,
    output alu_pkg::alu_resp_t resp
);
    import alu_pkg::*;

    alu_req_t  req;
    unit_out_t arith_out;
    unit_out_t logic_out;
    unit_out_t cmp_out;

    operand_stage u_operand_stage (
        .clk               (clk),
        .rst               (rst),
        .valid_instruction (valid_instruction),
        .opcode            (opcode),
        .operand_a         (operand_a),
        .operand_b         (operand_b),
        .use_immediate     (use_immediate),
        .immediate_value   (immediate_value),
        .req               (req)
    );

    // Execution units all see the stage-1 request
    adder_unit u_adder_unit (
        .req (req),
        .out (arith_out)
    );

    logic_shift_unit u_logic_shift_unit (
        .req (req),
        .out (logic_out)
    );

    compare_unit u_compare_unit (
        .req (req),
        .out (cmp_out)
    );

    result_stage u_result_stage (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .arith       (arith_out),
        .logic_shift (logic_out),
        .compare     (cmp_out),
        .resp        (resp)
    );

endmodule

// File: hw/logic_shift_unit.sv
// Logic and shift unit
module logic_shift_unit (
    input  alu_pkg::alu_req_t  req,
    output alu_pkg::unit_out_t out
);
    import alu_pkg::*;

    op_low_t               low;
    shamt_t                sh;
    logic [2*DATA_WIDTH-1:0] rot_l;
    logic [2*DATA_WIDTH-1:0] rot_r;
    data_t                 sar;

    assign low = req.opcode[LOW_WIDTH-1:0];
    assign sh  = req.b[SHAMT_WIDTH-1:0];                      // Shift amount from low bits of b

    // Rotates shift a doubled copy of a, so an amount of zero returns a
    assign rot_l = {req.a, req.a} << sh;
    assign rot_r = {req.a, req.a} >> sh;
    assign sar   = $signed(req.a) >>> sh;

    always_comb begin
        out = '0;                                             // No carry or overflow here
        case (low)
            op_low_t'(OP_AND):  out.result = req.a & req.b;
            op_low_t'(OP_OR):   out.result = req.a | req.b;
            op_low_t'(OP_XOR):  out.result = req.a ^ req.b;
            op_low_t'(OP_NOT):  out.result = ~req.a;
            op_low_t'(OP_NOR):  out.result = ~(req.a | req.b);
            op_low_t'(OP_SHL):  out.result = req.a << sh;
            op_low_t'(OP_SHR):  out.result = req.a >> sh;
            op_low_t'(OP_SAR):  out.result = sar;             // Sign fills from the left
            op_low_t'(OP_ROTL): out.result = rot_l[2*DATA_WIDTH-1:DATA_WIDTH];
            op_low_t'(OP_ROTR): out.result = rot_r[DATA_WIDTH-1:0];
            default:            out.result = '0;
        endcase
    end

endmodule

// File: hw/operand_stage.sv
// ALU operand stage
module operand_stage (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_instruction,
    input  alu_pkg::alu_op_e  opcode,
    input  alu_pkg::data_t    operand_a,
    input  alu_pkg::data_t    operand_b,
    input  logic              use_immediate,
    input  alu_pkg::data_t    immediate_value,
    output alu_pkg::alu_req_t req
);
    import alu_pkg::*;

    data_t b_sel;

    // Immediate replaces the register operand
    assign b_sel = use_immediate ? immediate_value : operand_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req <= '0;
        end else begin
            req.valid  <= valid_instruction;
            req.opcode <= opcode;
            req.a      <= operand_a;
            req.b      <= b_sel;
        end
    end

endmodule

// File: hw/result_stage.sv
// ALU result stage
module result_stage (
    input  logic               clk,
    input  logic               rst,
    input  alu_pkg::alu_req_t  req,
    input  alu_pkg::unit_out_t arith,
    input  alu_pkg::unit_out_t logic_shift,
    input  alu_pkg::unit_out_t compare,
    output alu_pkg::alu_resp_t resp
);
    import alu_pkg::*;

    op_class_t cls;
    unit_out_t sel;
    alu_resp_t resp_d;

    assign cls = req.opcode[OPCODE_WIDTH-1 -: CLASS_WIDTH];

    always_comb begin
        case (cls)
            CLASS_ARITH: sel = arith;
            CLASS_LOGIC: sel = logic_shift;
            CLASS_CMP:   sel = compare;
            default:     sel = '0;                            // Unused class reads as zero
        endcase
    end

    always_comb begin
        resp_d.valid    = req.valid;
        resp_d.result   = sel.result;
        resp_d.carry    = sel.carry;
        resp_d.overflow = sel.overflow;
        resp_d.zero     = (sel.result == '0);
        resp_d.negative = sel.result[DATA_WIDTH-1];
    end

    // An idle slot leaves an all-zero response behind it
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp <= '0;
        end else if (req.valid) begin
            resp <= resp_d;
        end else begin
            resp <= '0;
        end
    end

endmodule

// File: sim/alu_asserts.sv
// ALU core pipeline assertions
module alu_asserts (
    input logic               clk,
    input logic               rst,
    input logic               valid_instruction,
    input alu_pkg::alu_resp_t resp
);

    // Output valid trails the input valid by the pipeline depth
    valid_follows: assert property (
        @(posedge clk) disable iff (rst)
        resp.valid == $past(valid_instruction, 2)
    ) else $error("resp.valid does not follow valid_instruction two cycles later");

    idle_is_zero: assert property (
        @(posedge clk) disable iff (rst)
        !resp.valid |-> (resp == '0)
    ) else $error("resp has nonzero fields while valid is low");

    zero_flag: assert property (
        @(posedge clk) disable iff (rst)
        resp.valid |-> (resp.zero == (resp.result == '0))    // Flag tracks the result
    ) else $error("resp.zero disagrees with the result value");

endmodule

// File: sim/alu_model.svh
// ALU reference model
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// All ones for a true comparison
function automatic data_t mask_of(input logic cond);
    data_t m;
    m = cond ? '1 : '0;
    return m;
endfunction

// Expected response for one accepted instruction
function automatic alu_resp_t expected_resp(input alu_op_e op, input data_t a, input data_t b);
    alu_resp_t           r;
    longint              sa;
    longint              sb;
    longint              wide;
    longint              smax;
    longint              smin;
    logic [DATA_WIDTH:0] usum;
    int                  n;

    smax = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
    smin = -(longint'(1) <<< (DATA_WIDTH - 1));
    r = '0;
    r.valid = 1'b1;
    sa = $signed(a);                                 // Sign extended to 64 bits
    sb = $signed(b);
    n = int'(b[SHAMT_WIDTH-1:0]);
    usum = {1'b0, a} + {1'b0, b};
    wide = (op == OP_SUB || op == OP_SUBSAT) ? sa - sb : sa + sb;

    case (op)
        OP_ADD: begin
            r.result   = data_t'(wide);
            r.carry    = usum[DATA_WIDTH];
            r.overflow = (wide > smax) || (wide < smin);
        end
        OP_SUB: begin
            r.result   = data_t'(wide);
            r.carry    = (a < b);                    // Borrow
            r.overflow = (wide > smax) || (wide < smin);
        end
        OP_ADDSAT, OP_SUBSAT: begin
            r.overflow = (wide > smax) || (wide < smin);
            if (wide > smax) begin
                r.result = data_t'(smax);
            end else if (wide < smin) begin
                r.result = data_t'(smin);
            end else begin
                r.result = data_t'(wide);
            end
        end
        OP_AND:  r.result = a & b;
        OP_OR:   r.result = a | b;
        OP_XOR:  r.result = a ^ b;
        OP_NOT:  r.result = ~a;
        OP_NOR:  r.result = ~(a | b);
        OP_SHL:  r.result = a << n;
        OP_SHR:  r.result = a >> n;
        OP_SAR:  r.result = data_t'(sa >>> n);
        OP_ROTL: r.result = (n == 0) ? a : ((a << n) | (a >> (DATA_WIDTH - n)));
        OP_ROTR: r.result = (n == 0) ? a : ((a >> n) | (a << (DATA_WIDTH - n)));
        OP_EQ:   r.result = mask_of(a == b);
        OP_NE:   r.result = mask_of(a != b);
        OP_LTS:  r.result = mask_of(sa < sb);
        OP_LES:  r.result = mask_of(sa <= sb);
        OP_GTS:  r.result = mask_of(sa > sb);
        OP_GES:  r.result = mask_of(sa >= sb);
        OP_LTU:  r.result = mask_of(a < b);
        OP_LEU:  r.result = mask_of(a <= b);
        OP_GTU:  r.result = mask_of(a > b);
        OP_GEU:  r.result = mask_of(a >= b);
        default: r.result = '0;                      // Unknown codes give zero
    endcase

    r.zero     = (r.result == '0);
    r.negative = r.result[DATA_WIDTH-1];
    return r;
endfunction

`endif

// File: sim/alu_tb.sv
// ALU core testbench
module alu_tb;
    import alu_pkg::*;

    `include "alu_model.svh"

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 2;
    localparam int STIM_CYCLES    = 2000;
    localparam int PIPE_DEPTH     = 2;
    localparam int NUM_KEPT       = 24;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES + 100;       // Room for reset and drain

    typedef struct packed {
        logic [31:0] due;                                    // Slot where the response shows
        alu_op_e     op;
        alu_resp_t   exp;
    } pending_t;

    logic      clk;
    logic      rst;
    logic      valid_instruction;
    alu_op_e   opcode;
    data_t     operand_a;
    data_t     operand_b;
    logic      use_immediate;
    data_t     immediate_value;
    alu_resp_t resp;

    pending_t  pend_q[$];
    int        cycle_count = 0;
    int        slot;
    alu_op_e   kept_ops[NUM_KEPT] = '{
        OP_ADD, OP_SUB, OP_ADDSAT, OP_SUBSAT,
        OP_AND, OP_OR, OP_XOR, OP_NOT, OP_NOR,
        OP_SHL, OP_SHR, OP_SAR, OP_ROTL, OP_ROTR,
        OP_EQ, OP_NE, OP_LTS, OP_LES, OP_GTS, OP_GES,
        OP_LTU, OP_LEU, OP_GTU, OP_GEU
    };

    int_alu_core uut (
        .clk               (clk),
        .rst               (rst),
        .valid_instruction (valid_instruction),
        .opcode            (opcode),
        .operand_a         (operand_a),
        .operand_b         (operand_b),
        .use_immediate     (use_immediate),
        .immediate_value   (immediate_value),
        .resp              (resp)
    );

    bind int_alu_core alu_asserts u_asserts (
        .clk               (clk),
        .rst               (rst),
        .valid_instruction (valid_instruction),
        .resp              (resp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic check_value(input string what, input logic [DATA_WIDTH-1:0] got,
                               input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: %s got %h, expected %h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic is_kept(input logic [OPCODE_WIDTH-1:0] code);
        logic found;
        found = 1'b0;
        for (int i = 0; i < NUM_KEPT; i++) begin
            if (code == kept_ops[i]) found = 1'b1;
        end
        return found;
    endfunction

    function automatic alu_op_e other_opcode();
        logic [OPCODE_WIDTH-1:0] code;
        code = OPCODE_WIDTH'($urandom);
        while (is_kept(code)) code = OPCODE_WIDTH'($urandom);
        return alu_op_e'(code);
    endfunction

    // Corner values show up often enough to hit overflow and saturation
    function automatic data_t pick_operand();
        data_t v;
        case ($urandom_range(9, 0))
            0:       v = '0;
            1:       v = '1;
            2:       v = {1'b1, {(DATA_WIDTH-1){1'b0}}};
            3:       v = {1'b0, {(DATA_WIDTH-1){1'b1}}};
            default: v = $urandom;
        endcase
        return v;
    endfunction

    task automatic push_idle(input int s);
        pending_t p;
        p.due = s;
        p.op  = opcode;
        p.exp = '0;
        pend_q.push_back(p);
    endtask

    task automatic drive_instruction(input int s);
        pending_t p;
        data_t    b_eff;
        logic     go;
        go = ($urandom_range(99, 0) < 80);
        if ($urandom_range(99, 0) < 5) begin
            opcode = other_opcode();
        end else begin
            opcode = kept_ops[$urandom_range(NUM_KEPT - 1, 0)];
        end
        operand_a         = pick_operand();
        operand_b         = pick_operand();
        immediate_value   = pick_operand();
        use_immediate     = ($urandom_range(1, 0) == 1);
        valid_instruction = go;
        b_eff = use_immediate ? immediate_value : operand_b;
        p.due = s + PIPE_DEPTH;
        p.op  = opcode;
        p.exp = go ? expected_resp(opcode, operand_a, b_eff) : '0;   // Idle slot reads zero
        pend_q.push_back(p);
    endtask

    task automatic check_due(input int s);
        pending_t p;
        string    tag;
        if (pend_q.size() != 0 && pend_q[0].due == s) begin
            p = pend_q.pop_front();
            tag = $sformatf("slot %0d op %h", s, p.op);
            check_value({tag, " valid"}, resp.valid, p.exp.valid);
            check_value({tag, " result"}, resp.result, p.exp.result);
            check_value({tag, " carry"}, resp.carry, p.exp.carry);
            check_value({tag, " overflow"}, resp.overflow, p.exp.overflow);
            check_value({tag, " zero"}, resp.zero, p.exp.zero);
            check_value({tag, " negative"}, resp.negative, p.exp.negative);
        end
    endtask

    initial begin
        void'($urandom(32'h5cc6_16ce));
        clk               = 1'b0;
        rst               = 1'b1;
        valid_instruction = 1'b0;
        opcode            = OP_ADD;
        operand_a         = '0;
        operand_b         = '0;
        use_immediate     = 1'b0;
        immediate_value   = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Pipeline is empty for the first two slots after reset
        push_idle(0);
        push_idle(1);

        for (slot = 0; slot < STIM_CYCLES + PIPE_DEPTH; slot++) begin
            check_due(slot);
            if (slot < STIM_CYCLES) begin
                drive_instruction(slot);
            end else begin
                valid_instruction = 1'b0;                    // Drain
            end
            @(negedge clk);
        end

        if (pend_q.size() != 0) begin
            $display("%0d expected responses were never compared", pend_q.size());
            $display("Checks failed");
            $fatal(1, "Responses left unchecked");
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule
